/* compile.f */
hw/bus_pkg.sv
hw/mem_req_if.sv
hw/clint_timer.sv
hw/bus_arbiter.sv
hw/axi_lane_bridge.sv
hw/bus_top.sv
tests/bus_props.sv
tests/axi_mem_model.sv
tests/tb_bus_top.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_bus_top
FILELIST   := compile.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FLAGS      := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall
FAIL_MSG   := ** FAIL **
PASS_MSG   := ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "simulation did not finish, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/tb_bus_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_bus_top;

  localparam int WAIT_LIMIT  = 200;
  localparam int PULSE_IFU   = 0;
  localparam int PULSE_LOAD  = 1;
  localparam int PULSE_STORE = 2;

  logic                clk;
  logic                rst;
  bus_pkg::addr_t      ifu_araddr_i;
  logic                ifu_arvalid_i;
  bus_pkg::word_t      ifu_rdata_o;
  logic                ifu_rvalid_o;
  bus_pkg::addr_t      lsu_araddr_i;
  logic                lsu_arvalid_i;
  bus_pkg::req_strb_t  lsu_rstrb_i;
  bus_pkg::word_t      lsu_rdata_o;
  logic                lsu_rvalid_o;
  bus_pkg::addr_t      lsu_awaddr_i;
  bus_pkg::word_t      lsu_wdata_i;
  bus_pkg::req_strb_t  lsu_wstrb_i;
  logic                lsu_wvalid_i;
  logic                lsu_wready_o;
  logic                uart_tx_valid_o;
  logic [7:0]          uart_tx_data_o;
  bus_pkg::addr_t      araddr_o;
  bus_pkg::axsize_t    arsize_o;
  logic                arvalid_o;
  logic                arready_i;
  bus_pkg::beat_t      rdata_i;
  bus_pkg::resp_t      rresp_i;
  logic                rvalid_i;
  logic                rready_o;
  bus_pkg::addr_t      awaddr_o;
  bus_pkg::axsize_t    awsize_o;
  logic                awvalid_o;
  logic                awready_i;
  bus_pkg::beat_t      wdata_o;
  bus_pkg::strb_t      wstrb_o;
  logic                wlast_o;
  logic                wvalid_o;
  logic                wready_i;
  bus_pkg::resp_t      bresp_i;
  logic                bvalid_i;
  logic                bready_o;

  // expected memory contents kept up to date by stores
  logic [7:0]          shadow [0:2047];
  int                  error_count;
  bus_pkg::addr_t      exp_addr;
  bus_pkg::axsize_t    exp_size;
  bus_pkg::strb_t      exp_wstrb;
  bus_pkg::beat_t      exp_wdata;
  logic                ifu_req_q;
  logic                load_req_q;
  logic                store_req_q;

  bus_top bus_top_i (.*);

  axi_mem_model mem_model_i (
    .clk       (clk),
    .araddr_i  (araddr_o),
    .arvalid_i (arvalid_o),
    .arready_o (arready_i),
    .rdata_o   (rdata_i),
    .rresp_o   (rresp_i),
    .rvalid_o  (rvalid_i),
    .rready_i  (rready_o),
    .awaddr_i  (awaddr_o),
    .awvalid_i (awvalid_o),
    .awready_o (awready_i),
    .wdata_i   (wdata_o),
    .wstrb_i   (wstrb_o),
    .wvalid_i  (wvalid_o),
    .wready_o  (wready_i),
    .bresp_o   (bresp_i),
    .bvalid_o  (bvalid_i),
    .bready_i  (bready_o)
  );

  bind bus_top bus_props props_i (
    .clk          (clk),
    .rst          (rst),
    .arvalid_i    (arvalid_o),
    .arready_i    (arready_i),
    .awvalid_i    (awvalid_o),
    .awready_i    (awready_i),
    .rvalid_i     (rvalid_i),
    .rresp_i      (rresp_i),
    .bvalid_i     (bvalid_i),
    .bresp_i      (bresp_i),
    .ifu_rvalid_i (ifu_rvalid_o),
    .lsu_rvalid_i (lsu_rvalid_o),
    .lsu_wready_i (lsu_wready_o)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #50 clk = ~clk;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("** FAIL **");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp)
    begin
      error_count++;
      abort_run($sformatf("Fail %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // fill rule of the memory model preload
  function automatic logic [7:0] pattern_byte(input int a);
    logic [10:0] b;
    b = a[10:0];
    return b[7:0] ^ {b[10:8], 5'b00000} ^ 8'h3c;
  endfunction

  // masked bytes moved down to bit 0 and zero-extended
  function automatic bus_pkg::word_t load_expect(input bus_pkg::addr_t a,
                                                 input bus_pkg::req_strb_t m);
    bus_pkg::word_t v;
    v = '0;
    for (int k = 0; k < 4; k++)
      if (m[k])
        v[k * 8 +: 8] = shadow[int'(a[10:0]) + k];
    return v;
  endfunction

  function automatic bus_pkg::axsize_t size_code(input bus_pkg::req_strb_t m);
    case (m)
      4'h1:    return bus_pkg::SIZE_BYTE;
      4'h3:    return bus_pkg::SIZE_HALF;
      default: return bus_pkg::SIZE_WORD;
    endcase
  endfunction

  function automatic logic pulse_seen(input int sel);
    case (sel)
      PULSE_IFU:  return ifu_rvalid_o;
      PULSE_LOAD: return lsu_rvalid_o;
      default:    return lsu_wready_o;
    endcase
  endfunction

  // per-cycle look at the AXI side while a request is open
  task automatic watch_axi(input logic local_only);
    if (local_only)
    begin
      check_value("arvalid_o", 64'(arvalid_o), 64'd0);
      check_value("awvalid_o", 64'(awvalid_o), 64'd0);
      check_value("wvalid_o", 64'(wvalid_o), 64'd0);
      check_value("rready_o", 64'(rready_o), 64'd0);
      check_value("bready_o", 64'(bready_o), 64'd0);
    end
    else
    begin
      if (arvalid_o)
      begin
        check_value("araddr_o", 64'(araddr_o), 64'(exp_addr));
        check_value("arsize_o", 64'(arsize_o), 64'(exp_size));
        check_value("rready_o", 64'(rready_o), 64'd0);
      end
      if (awvalid_o)
      begin
        check_value("awaddr_o", 64'(awaddr_o), 64'(exp_addr));
        check_value("awsize_o", 64'(awsize_o), 64'(exp_size));
        check_value("bready_o", 64'(bready_o), 64'd0);
      end
      if (wvalid_o)
      begin
        check_value("wstrb_o", 64'(wstrb_o), 64'(exp_wstrb));
        check_value("wdata_o", wdata_o, exp_wdata);
        check_value("wlast_o", 64'(wlast_o), 64'd1);
      end
    end
  endtask

  task automatic wait_pulse(input int sel, input string what, input logic local_only);
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (!pulse_seen(sel))
    begin
      watch_axi(local_only);
      cycles++;
      if (cycles > WAIT_LIMIT)
        abort_run({"timed out waiting for the ", what, " response"});
      @(posedge clk);
    end
    watch_axi(local_only);
    // done lands on the r or b handshake
    if (!local_only)
    begin
      if (sel == PULSE_STORE)
        check_value("bready_o", 64'(bready_o), 64'd1);
      else
        check_value("rready_o", 64'(rready_o), 64'd1);
    end
  endtask

  task automatic fetch_check(input bus_pkg::addr_t a);
    @(negedge clk);
    ifu_araddr_i  = a;
    ifu_arvalid_i = 1'b1;
    exp_addr      = a;
    exp_size      = bus_pkg::SIZE_WORD;
    wait_pulse(PULSE_IFU, "fetch", 1'b0);
    check_value("ifu_rdata_o", 64'(ifu_rdata_o), 64'(load_expect(a, 4'hf)));
    @(negedge clk);
    ifu_arvalid_i = 1'b0;
  endtask

  task automatic load_check(input bus_pkg::addr_t a, input bus_pkg::req_strb_t m);
    @(negedge clk);
    lsu_araddr_i  = a;
    lsu_rstrb_i   = m;
    lsu_arvalid_i = 1'b1;
    exp_addr      = a;
    exp_size      = size_code(m);
    wait_pulse(PULSE_LOAD, "load", 1'b0);
    check_value("lsu_rdata_o", 64'(lsu_rdata_o), 64'(load_expect(a, m)));
    @(negedge clk);
    lsu_arvalid_i = 1'b0;
  endtask

  task automatic store_check(input bus_pkg::addr_t a, input bus_pkg::req_strb_t m,
                             input bus_pkg::word_t d);
    int off;
    int src;
    off       = int'(a[1:0]);
    exp_wstrb = '0;
    exp_wdata = '0;
    // data moves up by the byte offset on both halves and the strobe covers one half
    for (int j = 0; j < 8; j++)
    begin
      src = (j % 4) - off;
      if (src >= 0)
      begin
        exp_wdata[j * 8 +: 8] = d[src * 8 +: 8];
        if (m[src] && ((j / 4) == int'(a[2])))
          exp_wstrb[j] = 1'b1;
      end
    end
    @(negedge clk);
    lsu_awaddr_i = a;
    lsu_wdata_i  = d;
    lsu_wstrb_i  = m;
    lsu_wvalid_i = 1'b1;
    exp_addr     = a;
    exp_size     = size_code(m);
    wait_pulse(PULSE_STORE, "store", 1'b0);
    @(negedge clk);
    lsu_wvalid_i = 1'b0;
    for (int k = 0; k < 4; k++)
      if (m[k])
        shadow[int'(a[10:0]) + k] = d[k * 8 +: 8];
  endtask

  task automatic timer_read(input logic hi, output bus_pkg::word_t v);
    @(negedge clk);
    lsu_araddr_i  = hi ? bus_pkg::RTC_ADDR_UP : bus_pkg::RTC_ADDR;
    lsu_rstrb_i   = 4'hf;
    lsu_arvalid_i = 1'b1;
    wait_pulse(PULSE_LOAD, "timer read", 1'b1);
    v = lsu_rdata_o;
    @(negedge clk);
    lsu_arvalid_i = 1'b0;
  endtask

  task automatic timer_reads();
    bus_pkg::word_t hi_word;
    bus_pkg::word_t t0;
    bus_pkg::word_t t1;
    timer_read(1'b1, hi_word);
    check_value("lsu_rdata_o timer high word", 64'(hi_word), 64'd0);
    timer_read(1'b0, t0);
    repeat (20) @(negedge clk);
    timer_read(1'b0, t1);
    check_value("timer delta at least 20", 64'((t1 - t0) >= 32'd20), 64'd1);
  endtask

  task automatic fetch_words();
    fetch_check(32'h0000_0000);
    fetch_check(32'h0000_0004);
    fetch_check(32'h0000_03f8);
    fetch_check(32'h0000_07fc);
  endtask

  task automatic load_sizes();
    bus_pkg::addr_t bases [3];
    bases = '{32'h0000_0100, 32'h0000_0104, 32'h0000_06a8};
    foreach (bases[i])
    begin
      for (int off = 0; off < 4; off++)
        load_check(bases[i] + 32'(off), 4'h1);
      load_check(bases[i], 4'h3);
      load_check(bases[i] + 32'd2, 4'h3);
      load_check(bases[i], 4'hf);
    end
  endtask

  task automatic store_and_readback();
    store_check(32'h0000_0201, 4'h1, 32'h1122_33a5);
    store_check(32'h0000_0206, 4'h3, 32'h5566_beef);
    store_check(32'h0000_0208, 4'hf, 32'hcafe_f00d);
    store_check(32'h0000_020f, 4'h1, 32'h0000_0077);
    store_check(32'h0000_0200, 4'h3, 32'h0000_1234);
    // untouched bytes of the read-back words keep the fill pattern
    for (int w = 0; w < 4; w++)
      load_check(32'h0000_0200 + 32'(w * 4), 4'hf);
  endtask

  task automatic load_over_fetch();
    logic got_load;
    logic got_fetch;
    logic load_seen;
    logic fetch_seen;
    int   cycles;
    got_load  = 1'b0;
    got_fetch = 1'b0;
    cycles    = 0;
    @(negedge clk);
    lsu_araddr_i  = 32'h0000_0110;
    lsu_rstrb_i   = 4'hf;
    lsu_arvalid_i = 1'b1;
    ifu_araddr_i  = 32'h0000_0118;
    ifu_arvalid_i = 1'b1;
    while (!(got_load && got_fetch))
    begin
      @(posedge clk);
      load_seen  = lsu_rvalid_o;
      fetch_seen = ifu_rvalid_o;
      if (fetch_seen)
      begin
        check_value("lsu_rvalid_o before ifu_rvalid_o", 64'(got_load), 64'd1);
        check_value("ifu_rdata_o", 64'(ifu_rdata_o), 64'(load_expect(32'h118, 4'hf)));
        got_fetch = 1'b1;
      end
      if (load_seen)
      begin
        check_value("ifu_rvalid_o before lsu_rvalid_o", 64'(got_fetch), 64'd0);
        check_value("lsu_rdata_o", 64'(lsu_rdata_o), 64'(load_expect(32'h110, 4'hf)));
        got_load = 1'b1;
      end
      cycles++;
      if (cycles > WAIT_LIMIT)
        abort_run("timed out waiting for the load and fetch responses");
      @(negedge clk);
      if (load_seen)
        lsu_arvalid_i = 1'b0;
      if (fetch_seen)
        ifu_arvalid_i = 1'b0;
    end
  endtask

  task automatic serial_store();
    @(negedge clk);
    lsu_awaddr_i = bus_pkg::SERIAL_ADDR;
    lsu_wdata_i  = 32'h1234_5a6b;
    lsu_wstrb_i  = 4'h1;
    lsu_wvalid_i = 1'b1;
    wait_pulse(PULSE_STORE, "serial store", 1'b1);
    check_value("uart_tx_valid_o", 64'(uart_tx_valid_o), 64'd1);
    check_value("uart_tx_data_o", 64'(uart_tx_data_o), 64'h6b);
    @(negedge clk);
    lsu_wvalid_i = 1'b0;
    // no memory request may follow the local ack
    repeat (3)
    begin
      @(posedge clk);
      watch_axi(1'b1);
    end
  endtask

  // a pulse in a cycle needs the client's valid at the edge that opened it
  always @(posedge clk)
  begin
    if (rst)
    begin
      ifu_req_q   <= 1'b0;
      load_req_q  <= 1'b0;
      store_req_q <= 1'b0;
    end
    else
    begin
      check_value("ifu_rvalid_o unrequested", 64'(ifu_rvalid_o & ~ifu_req_q), 64'd0);
      check_value("lsu_rvalid_o unrequested", 64'(lsu_rvalid_o & ~load_req_q), 64'd0);
      check_value("lsu_wready_o unrequested", 64'(lsu_wready_o & ~store_req_q), 64'd0);
      check_value("uart_tx_valid_o unrequested", 64'(uart_tx_valid_o & ~store_req_q),
                  64'd0);
      ifu_req_q   <= ifu_arvalid_i;
      load_req_q  <= lsu_arvalid_i;
      store_req_q <= lsu_wvalid_i;
    end
  end

  initial
  begin
    error_count   = 0;
    rst           = 1'b1;
    ifu_araddr_i  = '0;
    ifu_arvalid_i = 1'b0;
    lsu_araddr_i  = '0;
    lsu_arvalid_i = 1'b0;
    lsu_rstrb_i   = '0;
    lsu_awaddr_i  = '0;
    lsu_wdata_i   = '0;
    lsu_wstrb_i   = '0;
    lsu_wvalid_i  = 1'b0;
    exp_addr      = '0;
    exp_size      = '0;
    exp_wstrb     = '0;
    exp_wdata     = '0;
    for (int a = 0; a < 2048; a++)
      shadow[a] = pattern_byte(a);
    repeat (8) @(negedge clk);
    rst = 1'b0;
    // timer first while the high word is still zero
    timer_reads();
    fetch_words();
    load_sizes();
    store_and_readback();
    load_over_fetch();
    serial_store();
    repeat (4) @(negedge clk);
    if (error_count == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

/* tests/axi_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model (
  input  wire             clk,
  // read channels
  input  bus_pkg::addr_t  araddr_i,
  input  wire             arvalid_i,
  output logic            arready_o,
  output bus_pkg::beat_t  rdata_o,
  output bus_pkg::resp_t  rresp_o,
  output logic            rvalid_o,
  input  wire             rready_i,
  // write channels
  input  bus_pkg::addr_t  awaddr_i,
  input  wire             awvalid_i,
  output logic            awready_o,
  input  bus_pkg::beat_t  wdata_i,
  input  bus_pkg::strb_t  wstrb_i,
  input  wire             wvalid_i,
  output logic            wready_o,
  output bus_pkg::resp_t  bresp_o,
  output logic            bvalid_o,
  input  wire             bready_i
);

  // 2 KiB, one beat per entry
  logic [63:0] mem [0:255];
  integer      seed;

  function automatic logic [7:0] fill_byte(input int a);
    logic [10:0] b;
    b = a[10:0];
    return b[7:0] ^ {b[10:8], 5'b00000} ^ 8'h3c;
  endfunction

  // ready and valid delays of 0 to 3 cycles
  function automatic int pick_delay();
    return $random(seed) & 3;
  endfunction

  initial
  begin
    seed      = 32'hbfa7a31b;
    arready_o = 1'b0;
    rvalid_o  = 1'b0;
    rdata_o   = '0;
    rresp_o   = bus_pkg::RESP_OKAY;
    awready_o = 1'b0;
    wready_o  = 1'b0;
    bvalid_o  = 1'b0;
    bresp_o   = bus_pkg::RESP_OKAY;
    for (int a = 0; a < 2048; a++)
      mem[a / 8][(a % 8) * 8 +: 8] = fill_byte(a);
  end

  // everything moves on the falling edge, handshakes land on the rising one
  initial
  begin : read_channel
    int         delay;
    logic [7:0] idx;
    forever
    begin
      @(negedge clk);
      if (arvalid_i)
      begin
        delay = pick_delay();
        repeat (delay) @(negedge clk);
        idx       = araddr_i[10:3];
        arready_o = 1'b1;
        @(negedge clk);
        arready_o = 1'b0;
        delay = pick_delay();
        repeat (delay) @(negedge clk);
        rdata_o  = mem[idx];
        rvalid_o = 1'b1;
        while (!rready_i)
          @(negedge clk);
        @(negedge clk);
        rvalid_o = 1'b0;
      end
    end
  end

  initial
  begin : write_channel
    int         aw_delay;
    int         w_delay;
    int         cycle;
    logic       aw_done;
    logic       w_done;
    logic [7:0] idx;
    forever
    begin
      @(negedge clk);
      if (awvalid_i && wvalid_i)
      begin
        aw_delay = pick_delay();
        w_delay  = pick_delay();
        aw_done  = 1'b0;
        w_done   = 1'b0;
        cycle    = 0;
        // aw and w accepted independently
        while (!(aw_done && w_done))
        begin
          awready_o = !aw_done && (cycle >= aw_delay);
          wready_o  = !w_done && (cycle >= w_delay);
          if (wready_o)
          begin
            idx = awaddr_i[10:3];
            for (int j = 0; j < 8; j++)
              if (wstrb_i[j])
                mem[idx][j * 8 +: 8] = wdata_i[j * 8 +: 8];
          end
          @(negedge clk);
          aw_done = aw_done | awready_o;
          w_done  = w_done | wready_o;
          cycle++;
        end
        awready_o = 1'b0;
        wready_o  = 1'b0;
        repeat (pick_delay()) @(negedge clk);
        bvalid_o = 1'b1;
        while (!bready_i)
          @(negedge clk);
        @(negedge clk);
        bvalid_o = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* tests/bus_props.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_props (
  input  wire             clk,
  input  wire             rst,
  input  wire             arvalid_i,
  input  wire             arready_i,
  input  wire             awvalid_i,
  input  wire             awready_i,
  input  wire             rvalid_i,
  input  bus_pkg::resp_t  rresp_i,
  input  wire             bvalid_i,
  input  bus_pkg::resp_t  bresp_i,
  input  wire             ifu_rvalid_i,
  input  wire             lsu_rvalid_i,
  input  wire             lsu_wready_i
);

  // address valids stay up until accepted
  ar_hold: assert property (@(posedge clk) disable iff (rst)
    arvalid_i && !arready_i |=> arvalid_i)
    else $error("arvalid dropped before arready");

  aw_hold: assert property (@(posedge clk) disable iff (rst)
    awvalid_i && !awready_i |=> awvalid_i)
    else $error("awvalid dropped before awready");

  // no slave errors expected from the memory
  r_okay: assert property (@(posedge clk) disable iff (rst)
    rvalid_i |-> rresp_i == bus_pkg::RESP_OKAY)
    else $error("read response not okay");

  b_okay: assert property (@(posedge clk) disable iff (rst)
    bvalid_i |-> bresp_i == bus_pkg::RESP_OKAY)
    else $error("write response not okay");

  // one client served per cycle
  one_pulse: assert property (@(posedge clk) disable iff (rst)
    $onehot0({ifu_rvalid_i, lsu_rvalid_i, lsu_wready_i}))
    else $error("more than one client response in a cycle");

endmodule

`default_nettype wire

/* hw/bus_top.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_top #(
  parameter int TIMER_W = 64
) (
  input  wire                 clk,
  input  wire                 rst,
  // fetch
  input  bus_pkg::addr_t      ifu_araddr_i,
  input  wire                 ifu_arvalid_i,
  output bus_pkg::word_t      ifu_rdata_o,
  output logic                ifu_rvalid_o,
  // load
  input  bus_pkg::addr_t      lsu_araddr_i,
  input  wire                 lsu_arvalid_i,
  input  bus_pkg::req_strb_t  lsu_rstrb_i,
  output bus_pkg::word_t      lsu_rdata_o,
  output logic                lsu_rvalid_o,
  // store
  input  bus_pkg::addr_t      lsu_awaddr_i,
  input  bus_pkg::word_t      lsu_wdata_i,
  input  bus_pkg::req_strb_t  lsu_wstrb_i,
  input  wire                 lsu_wvalid_i,
  output logic                lsu_wready_o,
  // serial
  output logic                uart_tx_valid_o,
  output logic [7:0]          uart_tx_data_o,
  // AXI master
  output bus_pkg::addr_t      araddr_o,
  output bus_pkg::axsize_t    arsize_o,
  output logic                arvalid_o,
  input  wire                 arready_i,
  input  bus_pkg::beat_t      rdata_i,
  input  bus_pkg::resp_t      rresp_i,
  input  wire                 rvalid_i,
  output logic                rready_o,
  output bus_pkg::addr_t      awaddr_o,
  output bus_pkg::axsize_t    awsize_o,
  output logic                awvalid_o,
  input  wire                 awready_i,
  output bus_pkg::beat_t      wdata_o,
  output bus_pkg::strb_t      wstrb_o,
  output logic                wlast_o,
  output logic                wvalid_o,
  input  wire                 wready_i,
  input  bus_pkg::resp_t      bresp_i,
  input  wire                 bvalid_i,
  output logic                bready_o
);

  logic            timer_rd;
  logic            timer_hi;
  bus_pkg::word_t  timer_rdata;
  logic            timer_rvalid;

  mem_req_if mem_req ();

  bus_arbiter arbiter_i (
    .clk             (clk),
    .rst             (rst),
    .ifu_araddr_i    (ifu_araddr_i),
    .ifu_arvalid_i   (ifu_arvalid_i),
    .ifu_rdata_o     (ifu_rdata_o),
    .ifu_rvalid_o    (ifu_rvalid_o),
    .lsu_araddr_i    (lsu_araddr_i),
    .lsu_arvalid_i   (lsu_arvalid_i),
    .lsu_rstrb_i     (lsu_rstrb_i),
    .lsu_rdata_o     (lsu_rdata_o),
    .lsu_rvalid_o    (lsu_rvalid_o),
    .lsu_awaddr_i    (lsu_awaddr_i),
    .lsu_wdata_i     (lsu_wdata_i),
    .lsu_wstrb_i     (lsu_wstrb_i),
    .lsu_wvalid_i    (lsu_wvalid_i),
    .lsu_wready_o    (lsu_wready_o),
    .uart_tx_valid_o (uart_tx_valid_o),
    .uart_tx_data_o  (uart_tx_data_o),
    .timer_rd_o      (timer_rd),
    .timer_hi_o      (timer_hi),
    .timer_rdata_i   (timer_rdata),
    .timer_rvalid_i  (timer_rvalid),
    .mem_o           (mem_req.arbiter)
  );

  axi_lane_bridge bridge_i (
    .clk       (clk),
    .rst       (rst),
    .mem_i     (mem_req.bridge),
    .araddr_o  (araddr_o),
    .arsize_o  (arsize_o),
    .arvalid_o (arvalid_o),
    .arready_i (arready_i),
    .rdata_i   (rdata_i),
    .rresp_i   (rresp_i),
    .rvalid_i  (rvalid_i),
    .rready_o  (rready_o),
    .awaddr_o  (awaddr_o),
    .awsize_o  (awsize_o),
    .awvalid_o (awvalid_o),
    .awready_i (awready_i),
    .wdata_o   (wdata_o),
    .wstrb_o   (wstrb_o),
    .wlast_o   (wlast_o),
    .wvalid_o  (wvalid_o),
    .wready_i  (wready_i),
    .bresp_i   (bresp_i),
    .bvalid_i  (bvalid_i),
    .bready_o  (bready_o)
  );

  clint_timer #(
    .TIMER_W (TIMER_W)
  ) timer_i (
    .clk      (clk),
    .rst      (rst),
    .rd_i     (timer_rd),
    .hi_i     (timer_hi),
    .rdata_o  (timer_rdata),
    .rvalid_o (timer_rvalid)
  );

endmodule

`default_nettype wire

/* hw/axi_lane_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_lane_bridge (
  input  wire                clk,
  input  wire                rst,
  mem_req_if.bridge          mem_i,
  // read address
  output bus_pkg::addr_t     araddr_o,
  output bus_pkg::axsize_t   arsize_o,
  output logic               arvalid_o,
  input  wire                arready_i,
  // read data
  input  bus_pkg::beat_t     rdata_i,
  input  bus_pkg::resp_t     rresp_i,
  input  wire                rvalid_i,
  output logic               rready_o,
  // write address
  output bus_pkg::addr_t     awaddr_o,
  output bus_pkg::axsize_t   awsize_o,
  output logic               awvalid_o,
  input  wire                awready_i,
  // write data
  output bus_pkg::beat_t     wdata_o,
  output bus_pkg::strb_t     wstrb_o,
  output logic               wlast_o,
  output logic               wvalid_o,
  input  wire                wready_i,
  // write response
  input  bus_pkg::resp_t     bresp_i,
  input  wire                bvalid_i,
  output logic               bready_o
);

  typedef enum logic [1:0] {BR_IDLE, BR_ADDR, BR_RDATA, BR_WRESP} br_state_e;

  br_state_e           state_q;
  logic                aw_fire;
  logic                w_fire;
  logic                resp_ok;
  logic [4:0]          lane_shift;
  bus_pkg::word_t      rd_half;
  bus_pkg::word_t      rd_shifted;
  bus_pkg::word_t      size_mask;
  bus_pkg::word_t      wr_lane;
  bus_pkg::req_strb_t  strb_lane;

  function automatic bus_pkg::axsize_t size_of(input bus_pkg::req_strb_t mask);
    case (mask)
      4'h1:    size_of = bus_pkg::SIZE_BYTE;
      4'h3:    size_of = bus_pkg::SIZE_HALF;
      default: size_of = bus_pkg::SIZE_WORD;
    endcase
  endfunction

  assign aw_fire = awvalid_o & awready_i;
  assign w_fire  = wvalid_o & wready_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q   <= BR_IDLE;
      arvalid_o <= 1'b0;
      awvalid_o <= 1'b0;
      wvalid_o  <= 1'b0;
    end
    else
    begin
      case (state_q)
        BR_IDLE:
        begin
          if (mem_i.req)
          begin
            state_q   <= BR_ADDR;
            arvalid_o <= ~mem_i.write;
            awvalid_o <= mem_i.write;
            wvalid_o  <= mem_i.write;
          end
        end
        BR_ADDR:
        begin
          if (mem_i.write)
          begin
            // aw and w may be accepted in either order
            if (aw_fire)
              awvalid_o <= 1'b0;
            if (w_fire)
              wvalid_o <= 1'b0;
            if ((~awvalid_o | aw_fire) & (~wvalid_o | w_fire))
              state_q <= BR_WRESP;
          end
          else if (arready_i)
          begin
            arvalid_o <= 1'b0;
            state_q   <= BR_RDATA;
          end
        end
        BR_RDATA:
        begin
          if (rvalid_i)
            state_q <= BR_IDLE;
        end
        BR_WRESP:
        begin
          if (bvalid_i)
            state_q <= BR_IDLE;
        end
        default:
          state_q <= BR_IDLE;
      endcase
    end
  end

  assign rready_o = (state_q == BR_RDATA);
  assign bready_o = (state_q == BR_WRESP);
  assign mem_i.done = ((state_q == BR_RDATA) & rvalid_i) |
                      ((state_q == BR_WRESP) & bvalid_i);

  assign araddr_o = mem_i.addr;
  assign awaddr_o = mem_i.addr;
  assign arsize_o = size_of(mem_i.mask);
  assign awsize_o = size_of(mem_i.mask);

  // byte offset within the word, in bits
  assign lane_shift = {mem_i.addr[1:0], 3'b000};

  // read path: pick the half, move down, clear above the access size
  assign rd_half    = mem_i.addr[2] ? rdata_i[63:32] : rdata_i[31:0];
  assign rd_shifted = rd_half >> lane_shift;
  assign size_mask  = {{8{mem_i.mask[3]}}, {8{mem_i.mask[2]}},
                       {8{mem_i.mask[1]}}, {8{mem_i.mask[0]}}};
  // a slave error hands back zero data
  assign resp_ok    = (state_q == BR_WRESP) ? (bresp_i == bus_pkg::RESP_OKAY)
                                            : (rresp_i == bus_pkg::RESP_OKAY);
  assign mem_i.rdata = resp_ok ? (rd_shifted & size_mask) : '0;

  // write path: same word on both halves, strobe selects the half
  assign wr_lane   = mem_i.wdata << lane_shift;
  assign strb_lane = mem_i.mask << mem_i.addr[1:0];
  assign wdata_o   = {wr_lane, wr_lane};
  assign wstrb_o   = mem_i.addr[2] ? {strb_lane, 4'b0000} : {4'b0000, strb_lane};
  assign wlast_o   = wvalid_o;

endmodule

`default_nettype wire

/* hw/bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
  input  wire                 clk,
  input  wire                 rst,
  // fetch
  input  bus_pkg::addr_t      ifu_araddr_i,
  input  wire                 ifu_arvalid_i,
  output bus_pkg::word_t      ifu_rdata_o,
  output logic                ifu_rvalid_o,
  // load
  input  bus_pkg::addr_t      lsu_araddr_i,
  input  wire                 lsu_arvalid_i,
  input  bus_pkg::req_strb_t  lsu_rstrb_i,
  output bus_pkg::word_t      lsu_rdata_o,
  output logic                lsu_rvalid_o,
  // store
  input  bus_pkg::addr_t      lsu_awaddr_i,
  input  bus_pkg::word_t      lsu_wdata_i,
  input  bus_pkg::req_strb_t  lsu_wstrb_i,
  input  wire                 lsu_wvalid_i,
  output logic                lsu_wready_o,
  // serial byte register
  output logic                uart_tx_valid_o,
  output logic [7:0]          uart_tx_data_o,
  // timer
  output logic                timer_rd_o,
  output logic                timer_hi_o,
  input  bus_pkg::word_t      timer_rdata_i,
  input  wire                 timer_rvalid_i,
  // towards the AXI bridge
  mem_req_if.arbiter          mem_o
);

  typedef enum logic [1:0] {ARB_IDLE, ARB_TIMER, ARB_MEM} arb_state_e;
  typedef enum logic [1:0] {OWN_IFU, OWN_LOAD, OWN_STORE} owner_e;

  arb_state_e state_q;
  owner_e     owner_q;
  logic       serial_ack_q;
  logic       lsu_rd_req;
  logic       lsu_wr_req;
  logic       rtc_hit;
  logic       serial_hit;
  logic       mem_done;

  // lsu is held off while its serial ack is still on the wire
  assign lsu_rd_req = lsu_arvalid_i & ~serial_ack_q;
  assign lsu_wr_req = lsu_wvalid_i & ~serial_ack_q;
  assign rtc_hit    = (lsu_araddr_i == bus_pkg::RTC_ADDR) |
                      (lsu_araddr_i == bus_pkg::RTC_ADDR_UP);
  assign serial_hit = (lsu_awaddr_i == bus_pkg::SERIAL_ADDR);
  assign mem_done   = (state_q == ARB_MEM) & mem_o.done;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q      <= ARB_IDLE;
      owner_q      <= OWN_IFU;
      mem_o.req    <= 1'b0;
      timer_rd_o   <= 1'b0;
      serial_ack_q <= 1'b0;
    end
    else
    begin
      timer_rd_o   <= 1'b0;
      serial_ack_q <= 1'b0;
      case (state_q)
        ARB_IDLE:
        begin
          // lsu first, then fetch
          if (lsu_rd_req & rtc_hit)
          begin
            state_q    <= ARB_TIMER;
            owner_q    <= OWN_LOAD;
            timer_rd_o <= 1'b1;
          end
          else if (lsu_wr_req & serial_hit)
          begin
            serial_ack_q <= 1'b1;
          end
          else if (lsu_wr_req)
          begin
            state_q   <= ARB_MEM;
            owner_q   <= OWN_STORE;
            mem_o.req <= 1'b1;
          end
          else if (lsu_rd_req)
          begin
            state_q   <= ARB_MEM;
            owner_q   <= OWN_LOAD;
            mem_o.req <= 1'b1;
          end
          else if (ifu_arvalid_i)
          begin
            state_q   <= ARB_MEM;
            owner_q   <= OWN_IFU;
            mem_o.req <= 1'b1;
          end
        end
        ARB_TIMER:
        begin
          if (timer_rvalid_i)
            state_q <= ARB_IDLE;
        end
        ARB_MEM:
        begin
          if (mem_o.done)
          begin
            mem_o.req <= 1'b0;
            state_q   <= ARB_IDLE;
          end
        end
        default:
          state_q <= ARB_IDLE;
      endcase
    end
  end

  // request fields follow the same priority, frozen once granted
  always_ff @(posedge clk)
  begin
    if (state_q == ARB_IDLE)
    begin
      if (lsu_wr_req)
      begin
        mem_o.write <= 1'b1;
        mem_o.addr  <= lsu_awaddr_i;
        mem_o.wdata <= lsu_wdata_i;
        mem_o.mask  <= lsu_wstrb_i;
      end
      else if (lsu_rd_req)
      begin
        mem_o.write <= 1'b0;
        mem_o.addr  <= lsu_araddr_i;
        mem_o.mask  <= lsu_rstrb_i;
      end
      else
      begin
        mem_o.write <= 1'b0;
        mem_o.addr  <= ifu_araddr_i;
        mem_o.mask  <= 4'hf;
      end
      timer_hi_o     <= (lsu_araddr_i == bus_pkg::RTC_ADDR_UP);
      uart_tx_data_o <= lsu_wdata_i[7:0];
    end
  end

  // responses go to the owner only
  assign ifu_rdata_o     = mem_o.rdata;
  assign ifu_rvalid_o    = mem_done & (owner_q == OWN_IFU);
  assign lsu_rdata_o     = (state_q == ARB_TIMER) ? timer_rdata_i : mem_o.rdata;
  assign lsu_rvalid_o    = (mem_done & (owner_q == OWN_LOAD)) |
                           ((state_q == ARB_TIMER) & timer_rvalid_i);
  assign lsu_wready_o    = serial_ack_q | (mem_done & (owner_q == OWN_STORE));
  assign uart_tx_valid_o = serial_ack_q;

endmodule

`default_nettype wire

/* hw/clint_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module clint_timer #(
  parameter int TIMER_W = 64
) (
  input  wire             clk,
  input  wire             rst,
  input  wire             rd_i,
  input  wire             hi_i,
  output bus_pkg::word_t  rdata_o,
  output logic            rvalid_o
);

  logic [TIMER_W-1:0] count_q;

  // free-running machine time
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count_q  <= '0;
      rvalid_o <= 1'b0;
    end
    else
    begin
      count_q  <= count_q + 1'b1;
      rvalid_o <= rd_i;
    end
  end

  // snapshot of the strobe cycle; upper word zero-extended
  always_ff @(posedge clk)
  begin
    if (rd_i)
    begin
      if (hi_i)
        rdata_o <= bus_pkg::word_t'(count_q[TIMER_W-1:32]);
      else
        rdata_o <= count_q[31:0];
    end
  end

endmodule

`default_nettype wire

/* hw/mem_req_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one granted request between arbiter and AXI bridge
interface mem_req_if;
  // held by the arbiter until done
  logic                req;
  logic                write;
  bus_pkg::addr_t      addr;
  bus_pkg::word_t      wdata;
  bus_pkg::req_strb_t  mask;
  // one-cycle pulse from the bridge, rdata valid with it
  logic                done;
  bus_pkg::word_t      rdata;

  modport arbiter (
    output req, write, addr, wdata, mask,
    input  done, rdata
  );

  modport bridge (
    input  req, write, addr, wdata, mask,
    output done, rdata
  );
endinterface

`default_nettype wire

/* hw/bus_pkg.sv */
`default_nettype none

package bus_pkg;

  // core-side and AXI-side widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [63:0] beat_t;
  typedef logic [7:0]  strb_t;
  // byte mask from the lsu: 1, 3 or f
  typedef logic [3:0]  req_strb_t;
  typedef logic [2:0]  axsize_t;
  typedef logic [1:0]  resp_t;

  // address map
  // timer low and high words
  localparam addr_t RTC_ADDR    = 32'ha000_0048;
  localparam addr_t RTC_ADDR_UP = RTC_ADDR + 32'd4;
  // serial byte register, store only
  localparam addr_t SERIAL_ADDR = 32'ha000_03f8;

  // AXI size codes for single beats
  localparam axsize_t SIZE_BYTE = 3'd0;
  localparam axsize_t SIZE_HALF = 3'd1;
  localparam axsize_t SIZE_WORD = 3'd2;

  localparam resp_t RESP_OKAY = 2'b00;

endpackage

`default_nettype wire
